// File: src/riscv_pkg.sv
//////////////////////////////
// shared sizes, memory map, opcodes and instruction formats
// for the core, the memory model and the testbench program table
//////////////////////////////
`default_nettype none

package riscv_pkg;

    // data path and memory sizes
    localparam int XLEN           = 32;
    localparam int RAM_ADDR_WIDTH = 12;

    localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_0080;

    // pseudo peripherals live well above the RAM window
    localparam logic [XLEN-1:0] PERIPH_BASE        = 32'h2000_0000;
    localparam logic [XLEN-1:0] TEST_STATUS_OFFSET = 32'h0000_0000;
    localparam logic [XLEN-1:0] EXIT_OFFSET        = 32'h0000_0004;
    localparam logic [XLEN-1:0] PASS_MAGIC         = 32'd123456789;

    // major opcodes of the supported RV32I subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct3 codes for the ALU and branch comparisons
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // the branch offset is scattered over the word, bit 0 is implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } instr_u;

    typedef enum logic [2:0] {
        FETCH, IWAIT, EXEC, DREQ, DWAIT, WB
    } core_state_e;

endpackage

`default_nettype wire

// File: src/riscv_regfile.sv
//////////////////////////////
// integer register file, x1 to x31, with two combinational
// read ports and one synchronous write port
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module riscv_regfile (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [4:0]  raddr_a_i,
    input  logic [4:0]  raddr_b_i,
    output logic [31:0] rdata_a_o,
    output logic [31:0] rdata_b_o,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i
);

    // x0 has no storage, it is hardwired to zero
    logic [31:0] regs [1:31];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = (raddr_a_i == 5'd0) ? 32'd0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == 5'd0) ? 32'd0 : regs[raddr_b_i];

endmodule

`default_nettype wire

// File: src/riscv_core.sv
//////////////////////////////
// multicycle RV32I subset core, one instruction in flight
// fetch, decode, execute, memory access and writeback in an FSM
// talks req/gnt/rvalid on separate instruction and data ports
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module riscv_core (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        fetch_enable_i,

    output logic        instr_req_o,
    output logic [31:0] instr_addr_o,
    input  logic        instr_gnt_i,
    input  logic        instr_rvalid_i,
    input  logic [31:0] instr_rdata_i,

    output logic        data_req_o,
    output logic [31:0] data_addr_o,
    output logic        data_we_o,
    output logic [3:0]  data_be_o,
    output logic [31:0] data_wdata_o,
    input  logic        data_gnt_i,
    input  logic        data_rvalid_i,
    input  logic [31:0] data_rdata_i
);

    riscv_pkg::core_state_e state_q;

    logic [31:0]     pc_q;
    riscv_pkg::instr_u instr_q;
    logic [31:0]     result_q;
    logic [31:0]     npc_q;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_u;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic [31:0] exec_res;
    logic [31:0] next_pc;
    logic        is_mem;
    logic        writes_rd;

    assign opcode = instr_q.r.opcode;
    assign funct3 = instr_q.r.funct3;

    // immediates, each decoded through the matching format view
    assign imm_i = {{20{instr_q.i.imm[11]}}, instr_q.i.imm};
    assign imm_s = {{20{instr_q.s.imm_hi[6]}}, instr_q.s.imm_hi, instr_q.s.imm_lo};
    assign imm_b = {{19{instr_q.b.imm12}}, instr_q.b.imm12, instr_q.b.imm11,
                    instr_q.b.imm10_5, instr_q.b.imm4_1, 1'b0};
    // U and J types reuse the R view, their fields cover bits 31 to 12
    assign imm_u = {instr_q.r.funct7, instr_q.r.rs2, instr_q.r.rs1, instr_q.r.funct3, 12'd0};
    assign imm_j = {{11{instr_q.r.funct7[6]}}, instr_q.r.funct7[6],
                    instr_q.r.rs1, instr_q.r.funct3, instr_q.r.rs2[0],
                    instr_q.r.funct7[5:0], instr_q.r.rs2[4:1], 1'b0};

    riscv_regfile regfile_i (
        .clk_i     ( clk_i           ),
        .rst_i     ( rst_i           ),
        .raddr_a_i ( instr_q.r.rs1   ),
        .raddr_b_i ( instr_q.r.rs2   ),
        .rdata_a_o ( rs1_data        ),
        .rdata_b_o ( rs2_data        ),
        .we_i      ( (state_q == riscv_pkg::WB) && writes_rd ),
        .waddr_i   ( instr_q.r.rd    ),
        .wdata_i   ( result_q        )
    );

    // OP takes rs2, OP-IMM takes the I immediate
    assign op_b = (opcode == riscv_pkg::OPC_OP) ? rs2_data : imm_i;

    always_comb begin
        case (funct3)
            riscv_pkg::F3_ADD: begin
                if ((opcode == riscv_pkg::OPC_OP) && instr_q.r.funct7[5]) begin
                    alu_res = rs1_data - op_b;
                end else begin
                    alu_res = rs1_data + op_b;
                end
            end
            riscv_pkg::F3_SLT: alu_res = {31'd0, $signed(rs1_data) < $signed(op_b)};
            riscv_pkg::F3_XOR: alu_res = rs1_data ^ op_b;
            riscv_pkg::F3_OR:  alu_res = rs1_data | op_b;
            riscv_pkg::F3_AND: alu_res = rs1_data & op_b;
            default:           alu_res = '0;
        endcase
    end

    // result, memory address and next PC for the instruction in EXEC
    always_comb begin
        exec_res  = alu_res;
        next_pc   = pc_q + 32'd4;
        is_mem    = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            riscv_pkg::OPC_LUI: begin
                exec_res  = imm_u;
                writes_rd = 1'b1;
            end
            riscv_pkg::OPC_OPIMM, riscv_pkg::OPC_OP: begin
                writes_rd = 1'b1;
            end
            riscv_pkg::OPC_LOAD: begin
                exec_res  = rs1_data + imm_i;
                is_mem    = 1'b1;
                writes_rd = 1'b1;
            end
            riscv_pkg::OPC_STORE: begin
                exec_res = rs1_data + imm_s;
                is_mem   = 1'b1;
            end
            riscv_pkg::OPC_BRANCH: begin
                if (((funct3 == riscv_pkg::F3_BEQ) && (rs1_data == rs2_data)) ||
                    ((funct3 == riscv_pkg::F3_BNE) && (rs1_data != rs2_data))) begin
                    next_pc = pc_q + imm_b;
                end
            end
            riscv_pkg::OPC_JAL: begin
                exec_res  = pc_q + 32'd4;
                next_pc   = pc_q + imm_j;
                writes_rd = 1'b1;
            end
            // anything outside the subset just moves on to the next word
            default: exec_res = alu_res;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= riscv_pkg::FETCH;
            pc_q    <= riscv_pkg::BOOT_ADDR;
        end else begin
            case (state_q)
                riscv_pkg::FETCH: if (instr_req_o && instr_gnt_i) state_q <= riscv_pkg::IWAIT;
                riscv_pkg::IWAIT: if (instr_rvalid_i) state_q <= riscv_pkg::EXEC;
                riscv_pkg::EXEC:  state_q <= is_mem ? riscv_pkg::DREQ : riscv_pkg::WB;
                riscv_pkg::DREQ:  if (data_gnt_i) state_q <= riscv_pkg::DWAIT;
                riscv_pkg::DWAIT: if (data_rvalid_i) state_q <= riscv_pkg::WB;
                riscv_pkg::WB: begin
                    pc_q    <= npc_q;
                    state_q <= riscv_pkg::FETCH;
                end
                default: state_q <= riscv_pkg::FETCH;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == riscv_pkg::IWAIT) && instr_rvalid_i) begin
            instr_q <= instr_rdata_i;
        end
        if (state_q == riscv_pkg::EXEC) begin
            result_q <= exec_res;
            npc_q    <= next_pc;
        end
        // load data replaces the address held in result_q
        if ((state_q == riscv_pkg::DWAIT) && data_rvalid_i && (opcode == riscv_pkg::OPC_LOAD)) begin
            result_q <= data_rdata_i;
        end
    end

    assign instr_req_o  = (state_q == riscv_pkg::FETCH) && fetch_enable_i;
    assign instr_addr_o = pc_q;

    assign data_req_o   = (state_q == riscv_pkg::DREQ);
    assign data_addr_o  = result_q;
    assign data_we_o    = (opcode == riscv_pkg::OPC_STORE);
    assign data_be_o    = 4'hf;
    assign data_wdata_o = rs2_data;

    // the two ports share no arbiter downstream, so they must never overlap
    assert property (@(posedge clk_i) disable iff (rst_i)
        !(instr_req_o && data_req_o));

    assert property (@(posedge clk_i) disable iff (rst_i)
        data_req_o |-> (data_addr_o[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: src/mm_ram.sv
//////////////////////////////
// word RAM with instruction and data ports, a program-load
// port and the pass, fail and exit pseudo peripherals
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module mm_ram (
    input  logic        clk_i,
    input  logic        rst_i,

    input  logic        instr_req_i,
    input  logic [31:0] instr_addr_i,
    output logic        instr_gnt_o,
    output logic        instr_rvalid_o,
    output logic [31:0] instr_rdata_o,

    input  logic        data_req_i,
    input  logic [31:0] data_addr_i,
    input  logic        data_we_i,
    input  logic [3:0]  data_be_i,
    input  logic [31:0] data_wdata_i,
    output logic        data_gnt_o,
    output logic        data_rvalid_o,
    output logic [31:0] data_rdata_o,

    input  logic        load_we_i,
    input  logic [riscv_pkg::RAM_ADDR_WIDTH-1:0] load_addr_i,
    input  logic [31:0] load_wdata_i,

    output logic        tests_passed_o,
    output logic        tests_failed_o,
    output logic        exit_valid_o,
    output logic [31:0] exit_value_o
);

    localparam int AW = riscv_pkg::RAM_ADDR_WIDTH;

    logic [31:0] mem [0:(2**AW)-1];

    logic [AW-1:0] instr_idx;
    logic [AW-1:0] data_idx;
    logic          periph_sel;
    logic          data_acc;
    logic          ram_wr;
    logic          periph_wr;

    // addresses above the RAM simply wrap, only word bits are decoded
    assign instr_idx = instr_addr_i[AW+1:2];
    assign data_idx  = data_addr_i[AW+1:2];

    assign periph_sel = (data_addr_i[31:8] == riscv_pkg::PERIPH_BASE[31:8]);

    // no contention anywhere, so every request is granted at once
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    assign data_acc  = data_req_i && data_gnt_o;
    assign ram_wr    = data_acc && data_we_i && !periph_sel;
    assign periph_wr = data_acc && data_we_i && periph_sel;

    always_ff @(posedge clk_i) begin
        if (load_we_i) begin
            mem[load_addr_i] <= load_wdata_i;
        end else if (ram_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (data_be_i[b]) begin
                    mem[data_idx][8*b +: 8] <= data_wdata_i[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_req_i && instr_gnt_o) begin
            instr_rdata_o <= mem[instr_idx];
        end
        // writes and peripheral reads return zero
        if (data_acc) begin
            if (data_we_i || periph_sel) begin
                data_rdata_o <= '0;
            end else begin
                data_rdata_o <= mem[data_idx];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            instr_rvalid_o <= 1'b0;
            data_rvalid_o  <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i && instr_gnt_o;
            data_rvalid_o  <= data_acc;
        end
    end

    // status flags are sticky until the next reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
            exit_value_o   <= '0;
        end else if (periph_wr) begin
            if (data_addr_i[7:0] == riscv_pkg::TEST_STATUS_OFFSET[7:0]) begin
                if (data_wdata_i == riscv_pkg::PASS_MAGIC) begin
                    tests_passed_o <= 1'b1;
                end else begin
                    tests_failed_o <= 1'b1;
                end
            end
            if (data_addr_i[7:0] == riscv_pkg::EXIT_OFFSET[7:0]) begin
                exit_value_o <= data_wdata_i;
                exit_valid_o <= 1'b1;
            end
        end
    end

    // program loading happens only while the core is held off the bus
    assert property (@(posedge clk_i) disable iff (rst_i)
        load_we_i |-> !(data_req_i || instr_req_i));

    assert property (@(posedge clk_i) disable iff (rst_i)
        instr_rvalid_o |-> $past(instr_req_i && instr_gnt_o));

    assert property (@(posedge clk_i) disable iff (rst_i)
        data_rvalid_o |-> $past(data_req_i && data_gnt_o));

endmodule

`default_nettype wire

// File: src/riscv_wrapper.sv
//////////////////////////////
// system top: the core joined to the RAM and pseudo
// peripherals, programs load while fetch_enable_i is low
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module riscv_wrapper (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        fetch_enable_i,

    input  logic        load_we_i,
    input  logic [riscv_pkg::RAM_ADDR_WIDTH-1:0] load_addr_i,
    input  logic [31:0] load_wdata_i,

    output logic        tests_passed_o,
    output logic        tests_failed_o,
    output logic [31:0] exit_value_o,
    output logic        exit_valid_o
);

    // core to memory, instruction side
    logic        instr_req;
    logic        instr_gnt;
    logic        instr_rvalid;
    logic [31:0] instr_addr;
    logic [31:0] instr_rdata;

    // core to memory, data side
    logic        data_req;
    logic        data_gnt;
    logic        data_rvalid;
    logic [31:0] data_addr;
    logic        data_we;
    logic [3:0]  data_be;
    logic [31:0] data_wdata;
    logic [31:0] data_rdata;

    riscv_core riscv_core_i (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .fetch_enable_i ( fetch_enable_i ),
        .instr_req_o    ( instr_req      ),
        .instr_addr_o   ( instr_addr     ),
        .instr_gnt_i    ( instr_gnt      ),
        .instr_rvalid_i ( instr_rvalid   ),
        .instr_rdata_i  ( instr_rdata    ),
        .data_req_o     ( data_req       ),
        .data_addr_o    ( data_addr      ),
        .data_we_o      ( data_we        ),
        .data_be_o      ( data_be        ),
        .data_wdata_o   ( data_wdata     ),
        .data_gnt_i     ( data_gnt       ),
        .data_rvalid_i  ( data_rvalid    ),
        .data_rdata_i   ( data_rdata     )
    );

    mm_ram ram_i (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .instr_req_i    ( instr_req      ),
        .instr_addr_i   ( instr_addr     ),
        .instr_gnt_o    ( instr_gnt      ),
        .instr_rvalid_o ( instr_rvalid   ),
        .instr_rdata_o  ( instr_rdata    ),
        .data_req_i     ( data_req       ),
        .data_addr_i    ( data_addr      ),
        .data_we_i      ( data_we        ),
        .data_be_i      ( data_be        ),
        .data_wdata_i   ( data_wdata     ),
        .data_gnt_o     ( data_gnt       ),
        .data_rvalid_o  ( data_rvalid    ),
        .data_rdata_o   ( data_rdata     ),
        .load_we_i      ( load_we_i      ),
        .load_addr_i    ( load_addr_i    ),
        .load_wdata_i   ( load_wdata_i   ),
        .tests_passed_o ( tests_passed_o ),
        .tests_failed_o ( tests_failed_o ),
        .exit_valid_o   ( exit_valid_o   ),
        .exit_value_o   ( exit_value_o   )
    );

endmodule

`default_nettype wire

// File: test/tb_programs.svh
//////////////////////////////
// table of test programs placed at BOOT_ADDR together with the
// exit value and status flags that each one must leave behind
//////////////////////////////
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int NUM_PROGS = 6;
localparam int MAX_WORDS = 24;

logic [31:0] prog_words [NUM_PROGS][MAX_WORDS];
int          prog_len   [NUM_PROGS];
logic [31:0] exp_exit   [NUM_PROGS];
logic        exp_pass   [NUM_PROGS];
logic        exp_fail   [NUM_PROGS];
string       prog_name  [NUM_PROGS];

task automatic append_word(input int p, input logic [31:0] w);
    prog_words[p][prog_len[p]] = w;
    prog_len[p]++;
endtask

// every program ends by pointing x31 at the peripherals and storing rs to the exit register
task automatic append_exit(input int p, input logic [4:0] rs);
    append_word(p, lui_word(5'd31, riscv_pkg::PERIPH_BASE[31:12]));
    append_word(p, s_word(rs, 5'd31, riscv_pkg::EXIT_OFFSET[11:0]));
endtask

task automatic set_expect(input int p, input string name, input logic [31:0] value,
                          input logic pass, input logic fail);
    prog_name[p] = name;
    exp_exit[p]  = value;
    exp_pass[p]  = pass;
    exp_fail[p]  = fail;
endtask

task automatic build_programs();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] lt_ba;
    logic [31:0] lt_ab;
    logic [31:0] sum;
    logic [31:0] magic_hi;
    for (int p = 0; p < NUM_PROGS; p++) begin
        prog_len[p] = 0;
    end

    // x2 holds minus 100 so SLT on these constants sees a signed compare
    append_word(0, lui_word(5'd1, 20'h12345));
    append_word(0, addi_word(5'd1, 5'd1, 12'h678));
    append_word(0, addi_word(5'd2, 5'd0, 12'hf9c));
    append_word(0, r_word(7'h00, riscv_pkg::F3_ADD, 5'd3, 5'd1, 5'd2));
    append_word(0, r_word(7'h20, riscv_pkg::F3_ADD, 5'd4, 5'd1, 5'd2));
    append_word(0, r_word(7'h00, riscv_pkg::F3_AND, 5'd5, 5'd1, 5'd2));
    append_word(0, r_word(7'h00, riscv_pkg::F3_OR, 5'd6, 5'd1, 5'd2));
    append_word(0, r_word(7'h00, riscv_pkg::F3_XOR, 5'd7, 5'd5, 5'd6));
    append_word(0, r_word(7'h00, riscv_pkg::F3_SLT, 5'd8, 5'd2, 5'd1));
    append_word(0, r_word(7'h00, riscv_pkg::F3_SLT, 5'd9, 5'd1, 5'd2));
    append_word(0, r_word(7'h00, riscv_pkg::F3_XOR, 5'd10, 5'd7, 5'd4));
    append_word(0, r_word(7'h00, riscv_pkg::F3_ADD, 5'd11, 5'd10, 5'd3));
    append_word(0, r_word(7'h00, riscv_pkg::F3_ADD, 5'd12, 5'd8, 5'd8));
    append_word(0, r_word(7'h00, riscv_pkg::F3_ADD, 5'd12, 5'd12, 5'd9));
    append_word(0, r_word(7'h20, riscv_pkg::F3_ADD, 5'd13, 5'd11, 5'd12));
    append_exit(0, 5'd13);
    a     = 32'h1234_5678;
    b     = 32'd0 - 32'd100;
    lt_ba = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
    lt_ab = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    set_expect(0, "arith", ((((a & b) ^ (a | b)) ^ (a - b)) + (a + b)) - (lt_ba + lt_ba + lt_ab),
               1'b0, 1'b0);

    // two stores and two loads to RAM above the program area
    append_word(1, lui_word(5'd1, 20'hcafe0));
    append_word(1, addi_word(5'd1, 5'd1, 12'h123));
    append_word(1, addi_word(5'd2, 5'd0, 12'h400));
    append_word(1, s_word(5'd1, 5'd2, 12'd8));
    append_word(1, s_word(5'd2, 5'd2, 12'd12));
    append_word(1, i_word(riscv_pkg::OPC_LOAD, 3'b010, 5'd4, 5'd2, 12'd8));
    append_word(1, i_word(riscv_pkg::OPC_LOAD, 3'b010, 5'd6, 5'd2, 12'd12));
    append_word(1, addi_word(5'd5, 5'd4, 12'd77));
    append_word(1, r_word(7'h00, riscv_pkg::F3_ADD, 5'd5, 5'd5, 5'd6));
    append_exit(1, 5'd5);
    set_expect(1, "load_store", 32'hcafe_0123 + 32'd77 + 32'h400, 1'b0, 1'b0);

    // a BNE loop over 1 to 10 and then a taken BEQ that jumps over a poisoning add
    append_word(2, addi_word(5'd1, 5'd0, 12'd0));
    append_word(2, addi_word(5'd2, 5'd0, 12'd1));
    append_word(2, addi_word(5'd3, 5'd0, 12'd11));
    append_word(2, r_word(7'h00, riscv_pkg::F3_ADD, 5'd1, 5'd1, 5'd2));
    append_word(2, addi_word(5'd2, 5'd2, 12'd1));
    append_word(2, b_word(riscv_pkg::F3_BNE, 5'd2, 5'd3, 13'h1ff8));
    append_word(2, b_word(riscv_pkg::F3_BEQ, 5'd1, 5'd1, 13'd8));
    append_word(2, addi_word(5'd1, 5'd1, 12'd100));
    append_exit(2, 5'd1);
    sum = 32'd0;
    for (int i = 1; i <= 10; i++) begin
        sum = sum + i;
    end
    set_expect(2, "branch_loop", sum, 1'b0, 1'b0);

    // JAL from the second word skips two words that would clobber x5
    append_word(3, addi_word(5'd1, 5'd0, 12'd5));
    append_word(3, jal_word(5'd5, 21'd12));
    append_word(3, addi_word(5'd5, 5'd0, 12'd1));
    append_word(3, addi_word(5'd5, 5'd0, 12'd99));
    append_exit(3, 5'd5);
    set_expect(3, "jal_link", riscv_pkg::BOOT_ADDR + 32'd4 + 32'd4, 1'b0, 1'b0);

    // ADDI sign extends the low part of the magic value so the upper part is rounded up
    magic_hi = riscv_pkg::PASS_MAGIC + 32'h800;
    append_word(4, lui_word(5'd31, riscv_pkg::PERIPH_BASE[31:12]));
    append_word(4, lui_word(5'd1, magic_hi[31:12]));
    append_word(4, addi_word(5'd1, 5'd1, riscv_pkg::PASS_MAGIC[11:0]));
    append_word(4, s_word(5'd1, 5'd31, riscv_pkg::TEST_STATUS_OFFSET[11:0]));
    append_word(4, addi_word(5'd2, 5'd0, 12'd7));
    append_exit(4, 5'd2);
    set_expect(4, "pass_flag", 32'd7, 1'b1, 1'b0);

    append_word(5, lui_word(5'd31, riscv_pkg::PERIPH_BASE[31:12]));
    append_word(5, addi_word(5'd1, 5'd0, 12'd1));
    append_word(5, s_word(5'd1, 5'd31, riscv_pkg::TEST_STATUS_OFFSET[11:0]));
    append_word(5, addi_word(5'd2, 5'd0, 12'd9));
    append_exit(5, 5'd2);
    set_expect(5, "fail_flag", 32'd9, 1'b0, 1'b1);
endtask

`endif

// File: test/riscv_wrapper_tb.sv
//////////////////////////////
// testbench for riscv_wrapper that loads each table program into
// noise-filled RAM, runs it to the exit write and checks the
// exit value and the pass and fail flags
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module riscv_wrapper_tb;

    localparam int RUN_TIMEOUT = 5000;
    localparam int RAM_WORDS   = 2 ** riscv_pkg::RAM_ADDR_WIDTH;

    logic        clk;
    logic        rst;
    logic        fetch_enable;
    logic        load_we;
    logic [11:0] load_addr;
    logic [31:0] load_wdata;
    logic        tests_passed;
    logic        tests_failed;
    logic [31:0] exit_value;
    logic        exit_valid;

    integer seed;
    int     errors;
    int     timeouts;

    riscv_wrapper DUT (
        .clk_i          ( clk          ),
        .rst_i          ( rst          ),
        .fetch_enable_i ( fetch_enable ),
        .load_we_i      ( load_we      ),
        .load_addr_i    ( load_addr    ),
        .load_wdata_i   ( load_wdata   ),
        .tests_passed_o ( tests_passed ),
        .tests_failed_o ( tests_failed ),
        .exit_value_o   ( exit_value   ),
        .exit_valid_o   ( exit_valid   )
    );

    always #4 clk = ~clk;

    // instruction encoders built on the format views of the package union
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        riscv_pkg::instr_u w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = riscv_pkg::OPC_OP;
        return w;
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        riscv_pkg::instr_u w;
        w.i.imm    = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = opc;
        return w;
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return i_word(riscv_pkg::OPC_OPIMM, riscv_pkg::F3_ADD, rd, rs1, imm);
    endfunction

    // only SW is encoded here and funct3 010 selects a whole word
    function automatic logic [31:0] s_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        riscv_pkg::instr_u w;
        w.s.imm_hi = imm[11:5];
        w.s.rs2    = rs2;
        w.s.rs1    = rs1;
        w.s.funct3 = 3'b010;
        w.s.imm_lo = imm[4:0];
        w.s.opcode = riscv_pkg::OPC_STORE;
        return w;
    endfunction

    function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        riscv_pkg::instr_u w;
        w.b.imm12   = off[12];
        w.b.imm10_5 = off[10:5];
        w.b.rs2     = rs2;
        w.b.rs1     = rs1;
        w.b.funct3  = f3;
        w.b.imm4_1  = off[4:1];
        w.b.imm11   = off[11];
        w.b.opcode  = riscv_pkg::OPC_BRANCH;
        return w;
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, riscv_pkg::OPC_LUI};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, riscv_pkg::OPC_JAL};
    endfunction

    `include "tb_programs.svh"

    task automatic expect_word(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic expect_bit(input string what, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // noise over the whole RAM first and then the program words at BOOT_ADDR
    task automatic load_program(input int p);
        for (int a = 0; a < RAM_WORDS; a++) begin
            @(negedge clk);
            load_we    = 1'b1;
            load_addr  = a[11:0];
            load_wdata = $random(seed);
        end
        for (int w = 0; w < prog_len[p]; w++) begin
            @(negedge clk);
            load_addr  = riscv_pkg::BOOT_ADDR[13:2] + w[11:0];
            load_wdata = prog_words[p][w];
        end
        @(negedge clk);
        load_we = 1'b0;
    endtask

    task automatic run_program(input int p);
        int cycles;
        @(negedge clk);
        rst          = 1'b1;
        fetch_enable = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // flags of the previous program must be gone before the core starts
        @(negedge clk);
        expect_bit($sformatf("%s tests_passed_o after reset", prog_name[p]), tests_passed, 1'b0);
        expect_bit($sformatf("%s tests_failed_o after reset", prog_name[p]), tests_failed, 1'b0);
        expect_bit($sformatf("%s exit_valid_o after reset", prog_name[p]), exit_valid, 1'b0);
        expect_word($sformatf("%s exit_value_o after reset", prog_name[p]), exit_value, 32'd0);

        load_program(p);
        fetch_enable = 1'b1;

        cycles = 0;
        while (!exit_valid && (cycles < RUN_TIMEOUT)) begin
            @(negedge clk);
            cycles++;
        end
        if (!exit_valid) begin
            $display("ERROR: program %s never wrote the exit register within %0d cycles",
                     prog_name[p], RUN_TIMEOUT);
            timeouts++;
        end else begin
            expect_word($sformatf("%s exit value", prog_name[p]), exit_value, exp_exit[p]);
            expect_bit($sformatf("%s tests_passed_o", prog_name[p]), tests_passed, exp_pass[p]);
            expect_bit($sformatf("%s tests_failed_o", prog_name[p]), tests_failed, exp_fail[p]);
        end
        fetch_enable = 1'b0;
    endtask

    initial begin
        seed         = 32'he1ec_7137;
        errors       = 0;
        timeouts     = 0;
        clk          = 1'b0;
        rst          = 1'b1;
        fetch_enable = 1'b0;
        load_we      = 1'b0;
        load_addr    = '0;
        load_wdata   = '0;
        build_programs();
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_program(p);
        end
        $display("summary: %0d check errors, %0d timeouts", errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: riscv_sys.f
+incdir+test
src/riscv_pkg.sv
src/riscv_regfile.sv
src/riscv_core.sv
src/mm_ram.sv
src/riscv_wrapper.sv
test/riscv_wrapper_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the riscv_sys testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f riscv_sys.f --top-module riscv_wrapper_tb -Mdir obj_dir > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vriscv_wrapper_tb > sim.log 2>&1 \
    || echo "simulator returned an error status"

grep -qx "Test passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
